// File: verilog/rom_layout_pkg.sv
package rom_layout_pkg;

    // header layout, byte positions within the first 64 bytes
    localparam int header_bytes = 64;   // bulk data starts here
    localparam int start_bytes  = 8;    // four 16-bit start points
    localparam int cfg_first    = 8;    // board config bytes
    localparam int cfg_last     = 39;
    localparam int flag_byte    = 39;   // config byte with decrypt/key_bit on [7:6]
    localparam int key_first    = 48;   // 88-bit key, msb byte first
    localparam int key_len      = 11;

    // bulk regions in image order
    typedef enum logic [2:0] {
        cpu  = 3'd0,
        snd  = 3'd1,
        pcm  = 3'd2,
        gfx  = 3'd3,
        qsnd = 3'd4
    } region_t;

    // region starts in KB units
    // snd_start sits lowest, since header bytes shift in from the top
    typedef struct packed {
        logic [15:0] qsnd_start;
        logic [15:0] gfx_start;
        logic [15:0] pcm_start;
        logic [15:0] snd_start;
    } start_table_t;

    // word offsets into program memory, per region
    localparam logic [21:0] cpu_offset = 22'h00_0000;
    localparam logic [21:0] snd_offset = 22'h10_0000;
    localparam logic [21:0] pcm_offset = 22'h11_0000;
    localparam logic [21:0] gfx_offset = 22'h00_0000;   // gfx has its own bank

    // cpu descramble table
    // one xor term per data bit, bit 0 first
    localparam logic [7:0] scramble_bit_mask [0:7] = '{
        8'h04, 8'h21, 8'h01, 8'h50, 8'h40, 8'h06, 8'h08, 8'h88
    };
    // bits 3 and 7 add their term when clear
    localparam logic [7:0] scramble_invert = 8'h88;

endpackage

// File: verilog/prog_bus_pkg.sv
package prog_bus_pkg;

    // one byte write toward the 16-bit program memory
    typedef struct packed {
        logic [21:0] addr;  // word address
        logic [ 7:0] data;
        logic [ 1:0] mask;  // active low, 10 = low byte lane
        logic [ 1:0] bank;
    } prog_wr_t;

    // board configuration write, header bytes 8..39
    typedef struct packed {
        logic [5:0] addr;   // low six bits of the header address
        logic [7:0] data;
    } cfg_wr_t;

    // memory bank codes
    localparam logic [1:0] bank_other = 2'b00;
    localparam logic [1:0] bank_cpu   = 2'b01;
    localparam logic [1:0] bank_gfx   = 2'b10;

endpackage

// File: verilog/header_capture.sv
`timescale 1ns/100ps

module header_capture (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        downloading,
    input  logic [24:0]                 ioctl_addr,
    input  logic [ 7:0]                 ioctl_data,
    input  logic                        ioctl_wr,
    output rom_layout_pkg::start_table_t starts,
    output logic                        decrypt,
    output logic                        key_bit,
    output logic                        cfg_we,
    output prog_bus_pkg::cfg_wr_t       cfg,
    output logic [87:0]                 key
);

    import rom_layout_pkg::*;

    logic accept;
    logic is_start;
    logic is_cfg;
    logic is_flag;
    logic is_key;

    assign accept   = ioctl_wr && downloading;
    assign is_start = ioctl_addr < start_bytes;
    assign is_cfg   = ioctl_addr >= cfg_first && ioctl_addr <= cfg_last;
    assign is_flag  = ioctl_addr == flag_byte;
    assign is_key   = ioctl_addr >= key_first && ioctl_addr < key_first + key_len;

    // control: cfg strobe and the two flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_we  <= 1'b0;
            decrypt <= 1'b0;
            key_bit <= 1'b0;
        end else begin
            cfg_we <= accept && is_cfg;     // single cycle per byte
            if (!downloading) begin
                decrypt <= 1'b0;            // flags live for one download only
                key_bit <= 1'b0;
            end else if (accept && is_flag) begin
                decrypt <= ioctl_data[7];
                key_bit <= ioctl_data[6];
            end
        end
    end

    // header payload
    always_ff @(posedge clk) begin
        if (accept) begin
            if (is_start) begin
                // shift in from the top, byte 0 ends in snd_start[7:0]
                starts <= {ioctl_data, starts[63:8]};
            end
            if (is_cfg) begin
                cfg.addr <= ioctl_addr[5:0];
                cfg.data <= ioctl_data;
            end
            if (is_key) begin
                key <= {key[79:0], ioctl_data};    // first byte ends at the top
            end
        end
    end

endmodule

// File: verilog/region_decode.sv
`timescale 1ns/100ps

module region_decode (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [ 7:0]                  ioctl_data,
    input  logic                         ioctl_wr,
    input  rom_layout_pkg::start_table_t starts,
    output prog_bus_pkg::prog_wr_t       item,
    output rom_layout_pkg::region_t      region,
    output logic                         item_valid,
    output logic                         bulk_bit19,
    output logic                         addr_bit0
);

    import rom_layout_pkg::*;
    import prog_bus_pkg::*;

    logic        is_bulk;
    logic [24:0] bulk_addr;     // header stripped
    logic [14:0] bulk_kb;       // KB index, compared against the start table
    region_t     region_c;
    logic [15:0] reg_start;
    logic [21:0] reg_offset;
    logic [24:0] rel_addr;
    logic [21:0] word_addr;
    logic [ 1:0] bank_c;

    assign is_bulk   = ioctl_addr >= header_bytes;
    assign bulk_addr = ioctl_addr - 25'(header_bytes);
    assign bulk_kb   = bulk_addr[24:10];

    always_comb begin
        // default is qsnd, which reuses the gfx start and offset
        region_c   = qsnd;
        reg_start  = starts.gfx_start;
        reg_offset = gfx_offset;
        if (bulk_kb < starts.snd_start) begin
            region_c   = cpu;
            reg_start  = 16'd0;     // cpu addresses straight from the bulk base
            reg_offset = cpu_offset;
        end else if (bulk_kb < starts.pcm_start) begin
            region_c   = snd;
            reg_start  = starts.snd_start;
            reg_offset = snd_offset;
        end else if (bulk_kb < starts.gfx_start) begin
            region_c   = pcm;
            reg_start  = starts.pcm_start;
            reg_offset = pcm_offset;
        end else if (bulk_kb < starts.qsnd_start) begin
            region_c = gfx;
        end
        rel_addr  = bulk_addr - {reg_start[14:0], 10'd0};
        word_addr = rel_addr[22:1] + reg_offset;   // byte to word
        case (region_c)
            cpu:     bank_c = bank_cpu;
            gfx:     bank_c = bank_gfx;
            default: bank_c = bank_other;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) item_valid <= 1'b0;
        else         item_valid <= ioctl_wr && downloading && is_bulk;
    end

    // item is held until the next bulk byte
    always_ff @(posedge clk) begin
        if (ioctl_wr && downloading && is_bulk) begin
            item.addr  <= word_addr;
            item.data  <= ioctl_data;
            item.mask  <= ioctl_addr[0] ? 2'b01 : 2'b10;   // even byte on the low lane
            item.bank  <= bank_c;
            region     <= region_c;
            bulk_bit19 <= bulk_addr[19];    // upper half of cpu space
            addr_bit0  <= bulk_addr[0];
        end
    end

endmodule

// File: verilog/byte_descramble.sv
`timescale 1ns/100ps

module byte_descramble (
    input  prog_bus_pkg::prog_wr_t  item_in,
    input  rom_layout_pkg::region_t region,
    input  logic                    bulk_bit19,
    input  logic                    addr_bit0,
    input  logic                    decrypt,
    input  logic                    key_bit,
    output prog_bus_pkg::prog_wr_t  item_out
);

    import rom_layout_pkg::*;

    logic       hit;
    logic [7:0] scrambled;

    // only odd or even cpu bytes in the upper half, picked by key_bit
    assign hit = region == cpu && bulk_bit19 && decrypt && (addr_bit0 != key_bit);

    always_comb begin
        scrambled = 8'h00;
        for (int i = 0; i < 8; i++) begin
            // inverted bits count when the data bit is clear
            if (item_in.data[i] ^ scramble_invert[i])
                scrambled ^= scramble_bit_mask[i];
        end
    end

    always_comb begin
        item_out = item_in;
        if (hit) item_out.data = scrambled;     // addr, mask, bank untouched
    end

endmodule

// File: verilog/prog_writer.sv
`timescale 1ns/100ps

module prog_writer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  prog_bus_pkg::prog_wr_t item,
    input  logic                   item_valid,
    input  logic                   is_qsnd,
    input  logic                   prog_ack,
    output prog_bus_pkg::prog_wr_t prog,
    output logic                   prog_req,
    output logic                   prom_we,
    output logic                   busy
);

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_request = 2'd1,     // prog_req up, waiting for ack
        st_release = 2'd2      // prog_req down, waiting for ack to fall
    } state_t;

    state_t state;
    logic   take;

    assign take = state == st_idle && item_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            prog_req <= 1'b0;
            prom_we  <= 1'b0;
        end else if (!downloading) begin
            state    <= st_idle;   // abandon any pending write
            prog_req <= 1'b0;
            prom_we  <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            case (state)
                st_idle: begin
                    if (item_valid) begin
                        if (is_qsnd) begin
                            prom_we <= 1'b1;    // internal rom, no handshake
                        end else begin
                            prog_req <= 1'b1;
                            state    <= st_request;
                        end
                    end
                end
                st_request: begin
                    if (prog_ack) begin
                        prog_req <= 1'b0;
                        state    <= st_release;
                    end
                end
                st_release: begin
                    if (!prog_ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // prog stays stable through the whole handshake
    always_ff @(posedge clk) begin
        if (take) prog <= item;
    end

    // high from the cycle the decoded item shows up
    assign busy = (state != st_idle) || (item_valid && !is_qsnd);

endmodule

// File: verilog/rom_loader.sv
`timescale 1ns/100ps

module rom_loader (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  logic [24:0]            ioctl_addr,
    input  logic [ 7:0]            ioctl_data,
    input  logic                   ioctl_wr,
    input  logic                   prog_ack,
    output prog_bus_pkg::prog_wr_t prog,
    output logic                   prog_req,
    output logic                   prom_we,    // qualifies prog for q-sound bytes
    output prog_bus_pkg::cfg_wr_t  cfg,
    output logic                   cfg_we,
    output logic                   busy,
    output logic [87:0]            key
);

    import rom_layout_pkg::*;
    import prog_bus_pkg::*;

    start_table_t starts;
    logic         decrypt;
    logic         key_bit;
    prog_wr_t     dec_item;     // straight from decode
    region_t      dec_region;
    logic         dec_valid;
    logic         bulk_bit19;
    logic         addr_bit0;
    prog_wr_t     wr_item;      // after descramble

    header_capture header_capture_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .starts      (starts),
        .decrypt     (decrypt),
        .key_bit     (key_bit),
        .cfg_we      (cfg_we),
        .cfg         (cfg),
        .key         (key)
    );

    region_decode region_decode_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .starts      (starts),
        .item        (dec_item),
        .region      (dec_region),
        .item_valid  (dec_valid),
        .bulk_bit19  (bulk_bit19),
        .addr_bit0   (addr_bit0)
    );

    byte_descramble byte_descramble_inst (
        .item_in    (dec_item),
        .region     (dec_region),
        .bulk_bit19 (bulk_bit19),
        .addr_bit0  (addr_bit0),
        .decrypt    (decrypt),
        .key_bit    (key_bit),
        .item_out   (wr_item)
    );

    prog_writer prog_writer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .item        (wr_item),
        .item_valid  (dec_valid),
        .is_qsnd     (dec_region == qsnd),
        .prog_ack    (prog_ack),
        .prog        (prog),
        .prog_req    (prog_req),
        .prom_we     (prom_we),
        .busy        (busy)
    );

endmodule

// File: tb/rom_loader_model.svh
`ifndef ROM_LOADER_MODEL_SVH
`define ROM_LOADER_MODEL_SVH

// cpu byte through the scramble table
function automatic logic [7:0] scramble_byte(logic [7:0] d);
    logic [7:0] r;
    logic       term;
    r = 8'h00;
    for (int i = 0; i < 8; i++) begin
        term = (i == 3 || i == 7) ? !d[i] : d[i];   // bits 3 and 7 count when clear
        if (term)
            r = r ^ scramble_bit_mask[i];
    end
    return r;
endfunction

// expected write of one bulk byte, returned as {is_qsnd, prog_wr_t}
function automatic logic [34:0] expected_write(logic [24:0] addr, logic [7:0] data,
                                               start_table_t st, logic dec, logic kbit);
    prog_wr_t    w;
    logic [24:0] bulk;
    logic [24:0] kb;
    logic [15:0] base_kb;   // region start in KB
    logic [21:0] offs;
    logic        qs;
    bulk    = addr - 25'(header_bytes);
    kb      = bulk >> 10;
    qs      = 1'b0;
    base_kb = st.gfx_start;                 // gfx layout, q-sound reuses it
    offs    = gfx_offset;
    w.bank  = bank_other;
    w.data  = data;
    w.mask  = addr[0] ? 2'b01 : 2'b10;      // even byte on the low lane
    if (kb < 25'(st.snd_start)) begin
        base_kb = 16'd0;
        offs    = cpu_offset;
        w.bank  = bank_cpu;
        if (bulk[19] && dec && bulk[0] != kbit)
            w.data = scramble_byte(data);   // upper half, picked parity
    end else if (kb < 25'(st.pcm_start)) begin
        base_kb = st.snd_start;
        offs    = snd_offset;
    end else if (kb < 25'(st.gfx_start)) begin
        base_kb = st.pcm_start;
        offs    = pcm_offset;
    end else if (kb < 25'(st.qsnd_start)) begin
        w.bank = bank_gfx;
    end else begin
        qs = 1'b1;                          // internal rom, bank stays 00
    end
    // byte offset in the region, halved to a word
    w.addr = offs + 22'((bulk - (25'(base_kb) << 10)) >> 1);
    return {qs, w};
endfunction

`endif

// File: tb/rom_loader_tb.sv
`timescale 1ns/100ps

module rom_loader_tb;

    import rom_layout_pkg::*;
    import prog_bus_pkg::*;

    `include "rom_loader_model.svh"

    localparam int timeout_cycles = 100;    // per wait loop

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_data;
    logic        ioctl_wr;
    logic        prog_ack;
    prog_wr_t    prog;
    logic        prog_req;
    logic        prom_we;
    cfg_wr_t     cfg;
    logic        cfg_we;
    logic        busy;
    logic [87:0] key;

    logic [31:0]  stim_rng;
    logic [31:0]  ack_rng;                  // own stream for the ack model
    logic         ack_enable;
    int           ack_wait;
    start_table_t table_sent;               // header as the testbench sent it
    logic         decrypt_sent;
    logic         key_bit_sent;
    logic [ 7:0]  key_bytes [0:10];
    logic [34:0]  write_queue [$];          // {is_qsnd, prog_wr_t}
    logic [13:0]  cfg_queue [$];            // {addr, data}

    rom_loader rom_loader_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    task automatic stop_on_error(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, logic [87:0] expected, logic [87:0] actual);
        if (expected !== actual)
            stop_on_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    endtask

    // called at a falling edge
    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy) begin
            n++;
            if (n > timeout_cycles)
                stop_on_error("timeout waiting for busy to fall");
            else
                @(negedge clk);
        end
    endtask

    task automatic wait_req(logic level);
        int n;
        n = 0;
        while (prog_req !== level) begin
            n++;
            if (n > timeout_cycles)
                stop_on_error("timeout waiting for prog_req to change");
            else
                @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (write_queue.size() != 0 || cfg_queue.size() != 0 || busy) begin
            n++;
            if (n > timeout_cycles)
                stop_on_error("timeout waiting for expected writes to arrive");
            else
                @(negedge clk);
        end
    endtask

    // one-cycle strobe, returns at the next falling edge
    task automatic send_byte(logic [24:0] addr, logic [7:0] data);
        wait_not_busy();
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
    endtask

    task automatic send_header_byte(int a, logic [7:0] d);
        if (a >= cfg_first && a <= cfg_last)
            cfg_queue.push_back({6'(a), d});
        if (a == flag_byte) begin
            decrypt_sent = d[7];
            key_bit_sent = d[6];
        end
        if (a >= key_first && a < key_first + key_len)
            key_bytes[a - key_first] = d;
        send_byte(25'(a), d);
    endtask

    task automatic send_header(logic [1:0] flags, int last);
        logic [7:0] d;
        for (int a = 0; a <= last; a++) begin
            d = 8'(next_rand());
            if (a < start_bytes)
                d = table_sent[8 * a +: 8];     // little-endian, snd_start first
            else if (a == flag_byte)
                d = {flags, d[5:0]};
            send_header_byte(a, d);
        end
    endtask

    task automatic send_bulk(logic [24:0] addr);
        logic [ 7:0] d;
        logic [34:0] w;
        d = 8'(next_rand());
        w = expected_write(addr, d, table_sent, decrypt_sent, key_bit_sent);
        write_queue.push_back(w);
        send_byte(addr, d);
        if (!w[34])
            check_value("busy", 88'd1, 88'(busy));  // memory write holds the source off
    endtask

    // random image address inside region r, 0 cpu up to 4 q-sound
    function automatic logic [24:0] region_addr(int r);
        logic [24:0] edges [0:5];
        logic [24:0] kb;
        edges[0] = 25'd0;
        edges[1] = 25'(table_sent.snd_start);
        edges[2] = 25'(table_sent.pcm_start);
        edges[3] = 25'(table_sent.gfx_start);
        edges[4] = 25'(table_sent.qsnd_start);
        edges[5] = edges[4] + 25'd256;      // 256 KB of q-sound
        kb = edges[r] + 25'(next_rand() % 32'(edges[r + 1] - edges[r]));
        return {kb[14:0], 10'(next_rand())} + 25'(header_bytes);
    endfunction

    // cpu byte with bulk bit 19 set, still below snd_start
    function automatic logic [24:0] upper_cpu_addr();
        return {6'd1, 19'(next_rand())} + 25'(header_bytes);
    endfunction

    // memory side, ack after 0 to 5 cycles, drop once req falls
    initial begin
        prog_ack = 1'b0;
        ack_wait = 0;
        forever begin
            @(negedge clk);
            if (prog_ack && !prog_req) begin
                prog_ack = 1'b0;
            end else if (!prog_req) begin
                ack_rng  = xorshift32(ack_rng);
                ack_wait = int'(ack_rng % 6);
            end else if (!prog_ack && ack_enable) begin
                if (ack_wait == 0)
                    prog_ack = 1'b1;
                else
                    ack_wait--;
            end
        end
    end

    // compare process, DUT outputs only move on the rising edge
    initial begin
        logic [34:0] exp_w;
        logic [13:0] exp_c;
        forever begin
            @(posedge clk);
            if (prog_req && prog_ack) begin     // handshake completes here
                if (write_queue.size() == 0)
                    stop_on_error("program write seen with nothing expected");
                else begin
                    exp_w = write_queue.pop_front();
                    check_value("prog_write", 88'(exp_w), 88'({1'b0, prog}));
                end
            end
            if (prom_we) begin
                if (write_queue.size() == 0)
                    stop_on_error("q-sound write seen with nothing expected");
                else begin
                    exp_w = write_queue.pop_front();
                    check_value("qsound_write", 88'(exp_w), 88'({1'b1, prog}));
                end
            end
            if (cfg_we) begin
                if (cfg_queue.size() == 0)
                    stop_on_error("configuration write seen with nothing expected");
                else begin
                    exp_c = cfg_queue.pop_front();
                    check_value("cfg_write", 88'(exp_c), 88'({cfg.addr, cfg.data}));
                end
            end
        end
    end

    initial begin
        logic [87:0] exp_key;
        arst_n       = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        stim_rng     = 32'h43825084;
        ack_rng      = {stim_rng[15:0], stim_rng[31:16]};
        ack_enable   = 1'b1;
        decrypt_sent = 1'b0;
        key_bit_sent = 1'b0;
        table_sent   = '{qsnd_start: 16'd3648, gfx_start: 16'd1600,
                         pcm_start: 16'd1088, snd_start: 16'd1024};
        repeat (5) @(negedge clk);
        arst_n      = 1'b1;
        @(negedge clk);
        downloading = 1'b1;

        // full header, decrypt and key_bit on
        send_header(2'b11, header_bytes - 1);
        for (int i = 0; i < key_len; i++)
            exp_key[87 - 8 * i -: 8] = key_bytes[i];   // first byte on top
        check_value("key", exp_key, key);

        // all regions, then a burst of upper cpu bytes
        repeat (80)
            send_bulk(region_addr(int'(next_rand() % 5)));
        repeat (30)
            send_bulk(upper_cpu_addr());

        // flag cleared through byte 39
        send_header_byte(flag_byte, 8'h00);
        repeat (20)
            send_bulk(upper_cpu_addr());
        wait_drained();

        // download ends with a request still waiting for ack
        send_header_byte(flag_byte, 8'hc0);     // flags up again, end of download clears them
        ack_enable = 1'b0;
        send_byte(upper_cpu_addr(), 8'(next_rand()));   // abandoned write
        wait_req(1'b1);
        downloading  = 1'b0;
        decrypt_sent = 1'b0;
        key_bit_sent = 1'b0;
        wait_req(1'b0);
        repeat (3) @(negedge clk);
        check_value("req_after_download_end", 88'd0, 88'(prog_req));
        ack_enable  = 1'b1;
        downloading = 1'b1;

        // next download, plain cpu bytes until byte 39
        send_header(2'b00, flag_byte - 1);
        repeat (20)
            send_bulk(upper_cpu_addr());
        send_header_byte(flag_byte, 8'h80);
        repeat (20)
            send_bulk(upper_cpu_addr());
        wait_drained();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tb
verilog/rom_layout_pkg.sv
verilog/prog_bus_pkg.sv
verilog/header_capture.sv
verilog/region_decode.sv
verilog/byte_descramble.sv
verilog/prog_writer.sv
verilog/rom_loader.sv
tb/rom_loader_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the rom_loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module rom_loader_tb \
    -o rom_loader_sim > build.log 2>&1 \
    && ./obj_dir/rom_loader_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; }
cat sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log 2>/dev/null && exit 1 || [ -s sim.log ] || exit 1
exit 0
